//--- logic/cache.sv
//////////////////////////////////////////////////
// direct-mapped write-back cache, write-allocate;
// one client port, one line-wide memory port
//////////////////////////////////////////////////

`include "mem_defs.svh"

`default_nettype none

module cache
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  cache_req_t req,
  output logic       rsp_valid,
  output cache_rsp_t rsp,
  output logic       mem_req_valid,
  output mem_req_t   mem_req,
  input  logic       grant,
  input  logic       mem_done,
  input  line_t      rline
);

  localparam int IDX_W = $clog2(`CACHE_LINES);
  localparam int TAG_W = `LINE_ADDR_BITS - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // tag, data and status stores
  tag_t                    tag_mem  [`CACHE_LINES];
  line_t                   data_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;
  logic [`CACHE_LINES-1:0] dirty;

  cache_state_t state;
  // access parked during a miss
  cache_req_t   req_q;

  idx_t       req_idx;
  idx_t       q_idx;
  tag_t       req_tag;
  tag_t       q_tag;
  line_t      cur_line;
  line_t      fill_line;
  line_t      wr_line;
  idx_t       wr_idx;
  logic       data_we;
  logic       accept;
  logic       lookup_hit;
  logic       victim_dirty;
  logic       mem_ack;
  logic       wb_done;
  logic       fill_done;
  cache_rsp_t rsp_d;

  // aligned word, or the addressed byte zero-extended
  function automatic word_t pick(line_t line, cache_req_t r);
    word_t      w;
    logic [1:0] wsel;
    logic [1:0] bsel;
    wsel = r.addr[`OFFSET_BITS-1:2];
    bsel = r.addr[1:0];
    w = line[wsel*`WORD_BITS +: `WORD_BITS];
    if (r.byte_op)
      w = {24'b0, w[bsel*8 +: 8]};
    return w;
  endfunction

  // store data merged into the line
  function automatic line_t merge(line_t line, cache_req_t r);
    line_t      l;
    word_t      w;
    logic [1:0] wsel;
    logic [1:0] bsel;
    l = line;
    wsel = r.addr[`OFFSET_BITS-1:2];
    bsel = r.addr[1:0];
    w = l[wsel*`WORD_BITS +: `WORD_BITS];
    if (r.byte_op)
      w[bsel*8 +: 8] = r.wdata[7:0];
    else
      w = r.wdata;
    l[wsel*`WORD_BITS +: `WORD_BITS] = w;
    return l;
  endfunction

  // address split, incoming and parked
  assign req_idx = req.addr[`OFFSET_BITS +: IDX_W];
  assign req_tag = req.addr[`ADDR_BITS-1 -: TAG_W];
  assign q_idx   = req_q.addr[`OFFSET_BITS +: IDX_W];
  assign q_tag   = req_q.addr[`ADDR_BITS-1 -: TAG_W];

  assign cur_line     = data_mem[req_idx];
  // respond counts as idle, a new strobe may follow the response
  assign accept       = req_valid && (state == idle || state == respond);
  assign lookup_hit   = valid[req_idx] && (tag_mem[req_idx] == req_tag);
  assign victim_dirty = valid[req_idx] && dirty[req_idx];
  // done only counts while we own the memory
  assign mem_ack      = grant && mem_done;
  assign wb_done      = (state == write_back) && mem_ack;
  assign fill_done    = (state == refill) && mem_ack;
  // pending write lands on the fresh line
  assign fill_line    = req_q.write ? merge(rline, req_q) : rline;

  // single data store write port, fill has priority
  always_comb
  begin
    data_we = 1'b0;
    wr_idx  = req_idx;
    wr_line = merge(cur_line, req);
    if (fill_done)
    begin
      data_we = 1'b1;
      wr_idx  = q_idx;
      wr_line = fill_line;
    end
    else if (accept && lookup_hit && req.write)
      data_we = 1'b1;
  end

  // writes answer with zero rdata
  always_comb
  begin
    if (fill_done)
    begin
      rsp_d.rdata = req_q.write ? word_t'(0) : pick(rline, req_q);
      rsp_d.hit   = 1'b0;
    end
    else
    begin
      rsp_d.rdata = req.write ? word_t'(0) : pick(cur_line, req);
      rsp_d.hit   = 1'b1;
    end
  end

  // FSM and line status
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state         <= idle;
      rsp_valid     <= 1'b0;
      mem_req_valid <= 1'b0;
      valid         <= '0;
      dirty         <= '0;
    end
    else
    begin
      // hit answers next cycle, miss right after the refill
      rsp_valid <= (accept && lookup_hit) || fill_done;
      case (state)
        idle, respond:
        begin
          state <= idle;
          if (accept && !lookup_hit)
          begin
            mem_req_valid <= 1'b1;
            if (victim_dirty)
              state <= write_back;
            else
              state <= refill;
          end
          if (accept && lookup_hit && req.write)
            dirty[req_idx] <= 1'b1;
        end
        write_back:
        begin
          // request stays up, it becomes the refill read
          if (mem_ack)
            state <= refill;
        end
        refill:
        begin
          if (mem_ack)
          begin
            mem_req_valid  <= 1'b0;
            valid[q_idx]   <= 1'b1;
            dirty[q_idx]   <= req_q.write;
            state          <= respond;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

  // stores and payload
  always_ff @(posedge clk)
  begin
    if (data_we)
      data_mem[wr_idx] <= wr_line;
    if (fill_done)
      tag_mem[q_idx] <= q_tag;
    if ((accept && lookup_hit) || fill_done)
      rsp <= rsp_d;
    if (accept && !lookup_hit)
    begin
      req_q <= req;
      if (victim_dirty)
        mem_req <= '{write: 1'b1, line: {tag_mem[req_idx], req_idx}, wline: cur_line};
      else
        mem_req <= '{write: 1'b0, line: req.addr[`ADDR_BITS-1:`OFFSET_BITS], wline: '0};
    end
    else if (wb_done)
      mem_req <= '{write: 1'b0, line: req_q.addr[`ADDR_BITS-1:`OFFSET_BITS], wline: '0};
  end

endmodule

`default_nettype wire

//--- logic/main_memory.sv
//////////////////////////////////////////////////
// line-wide main memory with fixed latency; reset
// loads the address pattern into every word
//////////////////////////////////////////////////

`include "mem_defs.svh"

`default_nettype none

module main_memory
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_start,
  input  mem_req_t mem_req,
  output logic     mem_done,
  output line_t    rline
);

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  line_t            store [`MEM_LINES];
  mem_req_t         req_q;
  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic             finish;

  // A5C3 on top, the word's byte address below
  function automatic line_t init_line(line_addr_t l);
    line_t line;
    addr_t a;
    line = '0;
    for (int w = 0; w < `LINE_BITS / `WORD_BITS; w++)
    begin
      a = {l, `OFFSET_BITS'(w * 4)};
      line[w*`WORD_BITS +: `WORD_BITS] = {16'ha5c3, 16'(a)};
    end
    return line;
  endfunction

  // last counting cycle, done is registered from here
  assign finish = busy && (cnt == CNT_W'(`MEM_LATENCY - 1));

  // latency counter
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      cnt      <= '0;
      mem_done <= 1'b0;
    end
    else
    begin
      mem_done <= finish;
      if (mem_start)
      begin
        busy <= 1'b1;
        cnt  <= CNT_W'(1);
      end
      else if (finish)
        busy <= 1'b0;
      else if (busy)
        cnt <= cnt + 1'b1;
    end
  end

  // request held for the access
  always_ff @(posedge clk)
  begin
    if (mem_start)
      req_q <= mem_req;
    if (finish && !req_q.write)
      rline <= store[req_q.line];
  end

  // storage, pattern load on reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `MEM_LINES; i++)
        store[i] <= init_line(line_addr_t'(i));
    end
    else if (finish && req_q.write)
      store[req_q.line] <= req_q.wline;
  end

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
//////////////////////////////////////////////////
// shares main memory between two caches; grant
// holds from mem_start until the done strobe
//////////////////////////////////////////////////

`default_nettype none

module mem_arbiter
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid_a,
  input  mem_req_t req_a,
  input  logic     req_valid_b,
  input  mem_req_t req_b,
  output logic     grant_a,
  output logic     grant_b,
  output logic     done_a,
  output logic     done_b,
  output logic     mem_start,
  output mem_req_t mem_req,
  input  logic     mem_done
);

  // memory in use, and by whom (1 = port b)
  logic busy;
  logic owner;
  // port served by the previous grant
  logic last_b;
  logic pick_b;

  // b wins alone, or on a tie when a went last
  assign pick_b = req_valid_b && (!req_valid_a || !last_b);

  assign grant_a = busy && !owner;
  assign grant_b = busy && owner;

  // done goes only to the owner
  assign done_a = mem_done && grant_a;
  assign done_b = mem_done && grant_b;

  // requester holds its request for the whole grant
  assign mem_req = owner ? req_b : req_a;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      owner     <= 1'b0;
      last_b    <= 1'b0;
      mem_start <= 1'b0;
    end
    else
    begin
      mem_start <= 1'b0;
      if (!busy)
      begin
        if (req_valid_a || req_valid_b)
        begin
          busy      <= 1'b1;
          owner     <= pick_b;
          last_b    <= pick_b;
          // one start per grant
          mem_start <= 1'b1;
        end
      end
      else if (mem_done)
        // free again, no regrant on the done edge
        busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/mem_defs.svh
//////////////////////////////////////////////////
// geometry, size and latency constants of the
// memory subsystem; include before using any macro
//////////////////////////////////////////////////

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`default_nettype none

// main memory depth in 128-bit lines, 16 KB total
`define MEM_LINES 1024

// lines per direct-mapped cache
`define CACHE_LINES 16

// cycles from mem_start to mem_done
`define MEM_LATENCY 6

// data widths
`define WORD_BITS 32
`define LINE_BITS 128

// byte address split: line number above the line offset
`define ADDR_BITS 14
`define LINE_ADDR_BITS 10
`define OFFSET_BITS 4

`default_nettype wire

`endif

//--- logic/mem_pkg.sv
//////////////////////////////////////////////////
// shared types of the memory subsystem: widths,
// client and memory request structs, cache FSM
//////////////////////////////////////////////////

`include "mem_defs.svh"

`default_nettype none

package mem_pkg;

  // byte address into main memory
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`WORD_BITS-1:0] word_t;
  // four words, word 0 in the low bits
  typedef logic [`LINE_BITS-1:0] line_t;
  // byte address without the line offset
  typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

  // client request, a single-cycle strobe alongside
  typedef struct packed {
    logic  write;
    logic  byte_op;
    addr_t addr;
    // byte writes use bits 7:0 only
    word_t wdata;
  } cache_req_t;

  typedef struct packed {
    word_t rdata;
    logic  hit;
  } cache_rsp_t;

  // line-wide request towards main memory
  typedef struct packed {
    logic       write;
    line_addr_t line;
    line_t      wline;
  } mem_req_t;

  // miss handling states
  typedef enum logic [1:0] {
    idle,
    write_back,
    refill,
    respond
  } cache_state_t;

endpackage

`default_nettype wire

//--- logic/mem_subsystem.sv
//////////////////////////////////////////////////
// memory side top: fetch and data caches sharing
// one main memory through the arbiter
//////////////////////////////////////////////////

`default_nettype none

module mem_subsystem
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       fetch_req_valid,
  input  cache_req_t fetch_req,
  output logic       fetch_rsp_valid,
  output cache_rsp_t fetch_rsp,
  input  logic       data_req_valid,
  input  cache_req_t data_req,
  output logic       data_rsp_valid,
  output cache_rsp_t data_rsp
);

  // fetch cache side of the arbiter (port a)
  logic     fetch_mem_req_valid;
  mem_req_t fetch_mem_req;
  logic     fetch_grant;
  logic     fetch_done;

  // data cache side (port b)
  logic     data_mem_req_valid;
  mem_req_t data_mem_req;
  logic     data_grant;
  logic     data_done;

  // shared memory bus
  logic     mem_start;
  mem_req_t mem_req;
  logic     mem_done;
  // read line goes to both, only the owner sees done
  line_t    rline;

  cache fetch_cache (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (fetch_req_valid),
    .req           (fetch_req),
    .rsp_valid     (fetch_rsp_valid),
    .rsp           (fetch_rsp),
    .mem_req_valid (fetch_mem_req_valid),
    .mem_req       (fetch_mem_req),
    .grant         (fetch_grant),
    .mem_done      (fetch_done),
    .rline         (rline)
  );

  cache data_cache (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (data_req_valid),
    .req           (data_req),
    .rsp_valid     (data_rsp_valid),
    .rsp           (data_rsp),
    .mem_req_valid (data_mem_req_valid),
    .mem_req       (data_mem_req),
    .grant         (data_grant),
    .mem_done      (data_done),
    .rline         (rline)
  );

  mem_arbiter arb (
    .clk         (clk),
    .rst         (rst),
    .req_valid_a (fetch_mem_req_valid),
    .req_a       (fetch_mem_req),
    .req_valid_b (data_mem_req_valid),
    .req_b       (data_mem_req),
    .grant_a     (fetch_grant),
    .grant_b     (data_grant),
    .done_a      (fetch_done),
    .done_b      (data_done),
    .mem_start   (mem_start),
    .mem_req     (mem_req),
    .mem_done    (mem_done)
  );

  main_memory main_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_start (mem_start),
    .mem_req   (mem_req),
    .mem_done  (mem_done),
    .rline     (rline)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module mem_subsystem_tb -o sim \
  && ./obj_dir/sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

//--- tb.f
+incdir+logic
logic/mem_pkg.sv
logic/cache.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/mem_subsystem.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

//--- verification/mem_subsystem_checker.sv
//////////////////////////////////////////////////
// handshake assertions, bound into mem_subsystem
//////////////////////////////////////////////////

`include "mem_defs.svh"

`default_nettype none

module mem_subsystem_checker (
  input wire logic clk,
  input wire logic rst,
  input wire logic fetch_req_valid,
  input wire logic fetch_rsp_valid,
  input wire logic data_req_valid,
  input wire logic data_rsp_valid,
  input wire logic mem_start,
  input wire logic mem_done,
  input wire logic fetch_grant,
  input wire logic data_grant
);
  timeunit 1ns;
  timeprecision 1ps;

  // one outstanding request per port
  logic fetch_pend;
  logic data_pend;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fetch_pend <= 1'b0;
      data_pend  <= 1'b0;
    end
    else
    begin
      if (fetch_req_valid)
        fetch_pend <= 1'b1;
      else if (fetch_rsp_valid)
        fetch_pend <= 1'b0;
      if (data_req_valid)
        data_pend <= 1'b1;
      else if (data_rsp_valid)
        data_pend <= 1'b0;
    end
  end

  // new strobe only once the response is out
  fetch_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    fetch_req_valid |-> (!fetch_pend || fetch_rsp_valid))
    else $error("fetch port strobed with a request outstanding");
  data_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    data_req_valid |-> (!data_pend || data_rsp_valid))
    else $error("data port strobed with a request outstanding");

  fetch_rsp_requested: assert property (@(posedge clk) disable iff (rst)
    fetch_rsp_valid |-> fetch_pend)
    else $error("fetch response without a request");
  data_rsp_requested: assert property (@(posedge clk) disable iff (rst)
    data_rsp_valid |-> data_pend)
    else $error("data response without a request");

  // fixed memory latency
  mem_latency: assert property (@(posedge clk) disable iff (rst)
    mem_start |-> ##`MEM_LATENCY mem_done)
    else $error("mem_done not at the fixed latency after mem_start");

  // at most one grant, and the memory answers only a granted port
  grant_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(fetch_grant && data_grant) && (!mem_done || fetch_grant || data_grant))
    else $error("grants overlap, or mem_done came with no grant");

endmodule

bind mem_subsystem mem_subsystem_checker chk (
  .clk             (clk),
  .rst             (rst),
  .fetch_req_valid (fetch_req_valid),
  .fetch_rsp_valid (fetch_rsp_valid),
  .data_req_valid  (data_req_valid),
  .data_rsp_valid  (data_rsp_valid),
  .mem_start       (mem_start),
  .mem_done        (mem_done),
  .fetch_grant     (fetch_grant),
  .data_grant      (data_grant)
);

`default_nettype wire

//--- verification/mem_subsystem_tb.sv
//////////////////////////////////////////////////
// testbench for mem_subsystem: directed and random
// traffic on both ports against a shadow memory
//////////////////////////////////////////////////

`include "mem_defs.svh"

`default_nettype none

module mem_subsystem_tb
  import mem_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MEM_BYTES = `MEM_LINES * 16;

  logic       clk;
  logic       rst;
  logic       fetch_req_valid;
  cache_req_t fetch_req;
  logic       fetch_rsp_valid;
  cache_rsp_t fetch_rsp;
  logic       data_req_valid;
  cache_req_t data_req;
  logic       data_rsp_valid;
  cache_rsp_t data_rsp;

  // shadow of main memory plus per-port tag model
  logic [7:0] shadow [MEM_BYTES];
  logic [5:0] tag_q [2][16];
  logic       tag_v [2][16];

  // per-port expectation, port 0 fetch, port 1 data
  logic  pend [2];
  word_t exp_rdata [2];
  logic  exp_hit [2];

  string  test_name;
  int     checks;
  int     errors;
  int     cycles;
  integer seed;

  mem_subsystem uut (
    .clk             (clk),
    .rst             (rst),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req       (fetch_req),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp       (fetch_rsp),
    .data_req_valid  (data_req_valid),
    .data_req        (data_req),
    .data_rsp_valid  (data_rsp_valid),
    .data_rsp        (data_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a response never came", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // expected rdata from the shadow memory
  function automatic word_t expected_rdata(cache_req_t r);
    int base;
    if (r.write)
      return word_t'(0);
    if (r.byte_op)
      return {24'b0, shadow[int'(r.addr)]};
    base = int'(r.addr) & ~3;
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
  endfunction

  // compares each response, sampled before the clock edge updates
  task automatic compare(input int p, input cache_rsp_t rsp);
    assert (pend[p])
    else
    begin
      $display("port %0d gave a response with no request outstanding", p);
      errors++;
    end
    checks++;
    assert (rsp.rdata == exp_rdata[p])
    else
    begin
      $display("FAILED %s rdata expected %h actual %h", test_name, exp_rdata[p], rsp.rdata);
      errors++;
    end
    assert (rsp.hit == exp_hit[p])
    else
    begin
      $display("FAILED %s hit expected %b actual %b", test_name, exp_hit[p], rsp.hit);
      errors++;
    end
    pend[p] = 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (fetch_rsp_valid)
        compare(0, fetch_rsp);
      if (data_rsp_valid)
        compare(1, data_rsp);
    end
  end

  // one request, waits for its response; lat in cycles after the strobe
  task automatic access(input int p, input logic wr, input logic bop, input int addr,
                        input word_t wdata, output int lat);
    cache_req_t r;
    int         idx;
    logic [5:0] tag;
    r.write   = wr;
    r.byte_op = bop;
    r.addr    = addr_t'(bop ? addr : addr & ~3);
    r.wdata   = wdata;
    idx = int'(r.addr[7:4]);
    tag = r.addr[13:8];
    exp_rdata[p] = expected_rdata(r);
    exp_hit[p]   = tag_v[p][idx] && (tag_q[p][idx] == tag);
    tag_v[p][idx] = 1'b1;
    tag_q[p][idx] = tag;
    if (wr && bop)
      shadow[int'(r.addr)] = wdata[7:0];
    else if (wr)
      for (int i = 0; i < 4; i++)
        shadow[int'(r.addr) + i] = wdata[i*8 +: 8];
    @(negedge clk);
    pend[p] = 1'b1;
    if (p == 0)
    begin
      fetch_req       = r;
      fetch_req_valid = 1'b1;
    end
    else
    begin
      data_req       = r;
      data_req_valid = 1'b1;
    end
    lat = 1;
    forever
    begin
      @(negedge clk);
      if (p == 0)
        fetch_req_valid = 1'b0;
      else
        data_req_valid = 1'b0;
      if ((p == 0) ? fetch_rsp_valid : data_rsp_valid)
        break;
      lat++;
    end
    wait (pend[p] == 1'b0);
  endtask

  task automatic report_test(input int err_before);
    $display("test %s done, %0d errors", test_name, errors - err_before);
  endtask

  // fetch port reads only its lower half
  task automatic fetch_traffic(input int n);
    int lat;
    int a;
    for (int i = 0; i < n; i++)
    begin
      a = $random(seed) & 32'h1fff;
      access(0, 1'b0, a[0], a, word_t'(0), lat);
    end
  endtask

  task automatic data_traffic(input int n);
    int    lat;
    int    a;
    word_t d;
    for (int i = 0; i < n; i++)
    begin
      a = 32'h2000 | ($random(seed) & 32'h1fff);
      d = $random(seed);
      access(1, d[31], a[0], a, d, lat);
    end
  endtask

  initial
  begin
    int lat;
    int e0;
    seed = 79;
    checks = 0;
    errors = 0;
    cycles = 0;
    rst = 1'b1;
    fetch_req_valid = 1'b0;
    fetch_req = '0;
    data_req_valid = 1'b0;
    data_req = '0;
    for (int p = 0; p < 2; p++)
    begin
      pend[p] = 1'b0;
      exp_rdata[p] = '0;
      exp_hit[p] = 1'b0;
      for (int i = 0; i < 16; i++)
      begin
        tag_v[p][i] = 1'b0;
        tag_q[p][i] = '0;
      end
    end
    // A5C3 over the word's byte address
    for (int a = 0; a < MEM_BYTES; a += 4)
    begin
      shadow[a]   = 8'(a);
      shadow[a+1] = 8'(a >> 8);
      shadow[a+2] = 8'hc3;
      shadow[a+3] = 8'ha5;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle a while, a stray response is caught by the comparator
    repeat (10) @(negedge clk);

    test_name = "first_read";
    e0 = errors;
    access(0, 1'b0, 1'b0, 32'h0100, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h2100, word_t'(0), lat);
    report_test(e0);

    test_name = "write_then_read";
    e0 = errors;
    access(1, 1'b1, 1'b0, 32'h2010, 32'hdeadbeef, lat);
    access(1, 1'b0, 1'b0, 32'h2010, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h2014, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h2018, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h201c, word_t'(0), lat);
    report_test(e0);

    test_name = "byte_lanes";
    e0 = errors;
    for (int b = 0; b < 4; b++)
      access(1, 1'b1, 1'b1, 32'h2048 + b, word_t'(8'h11 * (b + 1)), lat);
    for (int b = 0; b < 4; b++)
      access(1, 1'b0, 1'b1, 32'h2048 + b, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h2048, word_t'(0), lat);
    report_test(e0);

    test_name = "evictions";
    e0 = errors;
    // index 3, three tags, each write dirties the line
    for (int t = 0; t < 3; t++)
      access(1, 1'b1, 1'b0, 32'h2030 + t * 32'h100, word_t'(32'h1000 + t), lat);
    for (int t = 0; t < 3; t++)
      access(1, 1'b0, 1'b0, 32'h2030 + t * 32'h100, word_t'(0), lat);
    access(1, 1'b1, 1'b1, 32'h2131, word_t'(32'h7e), lat);
    access(1, 1'b0, 1'b0, 32'h2030, word_t'(0), lat);
    access(1, 1'b0, 1'b0, 32'h2130, word_t'(0), lat);
    report_test(e0);

    test_name = "random_both_ports";
    e0 = errors;
    fork
      fetch_traffic(300);
      data_traffic(300);
    join
    report_test(e0);

    test_name = "latency";
    e0 = errors;
    access(0, 1'b0, 1'b0, 32'h0ff0, word_t'(0), lat);
    // clean miss: request, grant, memory, registered done and response
    access(0, 1'b0, 1'b0, 32'h1ff0, word_t'(0), lat);
    assert (lat == `MEM_LATENCY + 3)
    else
    begin
      $display("FAILED %s miss latency expected %0d actual %0d", test_name,
               `MEM_LATENCY + 3, lat);
      errors++;
    end
    access(0, 1'b0, 1'b0, 32'h1ff4, word_t'(0), lat);
    assert (lat == 1)
    else
    begin
      $display("FAILED %s hit latency expected %0d actual %0d", test_name, 1, lat);
      errors++;
    end
    report_test(e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
